// File: Bender.yml
package:
  name: rv_pipe

sources:
  - common/rv_pkg.sv
  - common/rv_stage_if.sv
  - fetch/fetch_stage.sv
  - decode/reg_bank.sv
  - decode/decode_stage.sv
  - verilog/alu_stage.sv
  - verilog/mem_stage.sv
  - verilog/rv_pipe_top.sv
  - target: test
    files:
      - tests/rv_pipe_checker.sv
      - tests/rv_pipe_tb.sv

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN     = 32;
  localparam int REG_AW   = 5;
  localparam int NUM_REGS = 32;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    opcode_e           opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]       imm;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    opcode_e           opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0]        imm_hi;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [4:0]        imm_lo;
    opcode_e           opcode;
  } s_type_t;

  // Branch offset bits are scattered, bit 0 is implied zero
  typedef struct packed {
    logic              imm12;
    logic [5:0]        imm10_5;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [3:0]        imm4_1;
    logic              imm11;
    opcode_e           opcode;
  } b_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
  } instr_u;

endpackage

`default_nettype wire

// File: common/rv_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_dec_if #(
  parameter int ADDR_WIDTH = 16
);
  logic                    valid;
  logic [ADDR_WIDTH-1:0]   pc;
  logic [rv_pkg::XLEN-1:0] instr;
  logic                    stall;

  modport producer (output valid, pc, instr, input stall);
  modport consumer (input valid, pc, instr, output stall);
endinterface

interface dec_alu_if #(
  parameter int ADDR_WIDTH = 16
);
  logic                      valid;
  logic [ADDR_WIDTH-1:0]     pc;
  rv_pkg::alu_op_e           alu_op;
  logic [rv_pkg::XLEN-1:0]   op_a;
  logic [rv_pkg::XLEN-1:0]   op_b;
  logic [rv_pkg::XLEN-1:0]   store_data;
  logic [rv_pkg::REG_AW-1:0] rd;
  logic                      wr_en;
  logic                      is_load;
  logic                      is_store;
  logic                      is_branch;
  logic                      branch_ne;
  logic [ADDR_WIDTH-1:0]     branch_offset;
  logic                      stall;

  modport producer (output valid, pc, alu_op, op_a, op_b, store_data, rd, wr_en, is_load,
                    is_store, is_branch, branch_ne, branch_offset, input stall);
  modport consumer (input valid, pc, alu_op, op_a, op_b, store_data, rd, wr_en, is_load,
                    is_store, is_branch, branch_ne, branch_offset, output stall);
  modport monitor (input valid, rd, wr_en);
endinterface

interface alu_mem_if;
  logic                      valid;
  logic [rv_pkg::XLEN-1:0]   result;
  logic [rv_pkg::XLEN-1:0]   store_data;
  logic [rv_pkg::REG_AW-1:0] rd;
  logic                      wr_en;
  logic                      is_load;
  logic                      is_store;
  logic                      stall;

  modport producer (output valid, result, store_data, rd, wr_en, is_load, is_store,
                    input stall);
  modport consumer (input valid, result, store_data, rd, wr_en, is_load, is_store,
                    output stall);
  modport monitor (input valid, rd, wr_en);
endinterface

`default_nettype wire

// File: decode/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
  parameter int ADDR_WIDTH = 16
) (
  input  wire                       clk_i,
  input  wire                       rst_i,
  input  wire                       redirect_i,
  input  wire  [rv_pkg::XLEN-1:0]   rs1_data_i,
  input  wire  [rv_pkg::XLEN-1:0]   rs2_data_i,
  output logic [rv_pkg::REG_AW-1:0] rs1_idx_o,
  output logic [rv_pkg::REG_AW-1:0] rs2_idx_o,
  fetch_dec_if.consumer             fetch_i,
  dec_alu_if.producer               alu_o,
  dec_alu_if.monitor                alu_mon_i,
  alu_mem_if.monitor                mem_mon_i
);

  rv_pkg::instr_u          ins;
  rv_pkg::opcode_e         opc;
  rv_pkg::alu_op_e         alu_op;
  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] imm_s;
  logic [rv_pkg::XLEN-1:0] imm_b;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic                    uses_rs2;
  logic                    wr_en;
  logic                    is_branch;
  logic                    hazard;

  assign ins       = fetch_i.instr;
  assign opc       = ins.r.opcode;
  assign rs1_idx_o = ins.r.rs1;
  assign rs2_idx_o = ins.r.rs2;

  assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
  assign imm_s = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
  assign imm_b = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10_5,
                  ins.b.imm4_1, 1'b0};

  assign is_branch = (opc == rv_pkg::BRANCH) &&
                     (ins.b.funct3 == rv_pkg::F3_BEQ || ins.b.funct3 == rv_pkg::F3_BNE);
  assign uses_rs2  = opc inside {rv_pkg::OP, rv_pkg::STORE, rv_pkg::BRANCH};
  assign wr_en     = (opc inside {rv_pkg::OP, rv_pkg::OP_IMM, rv_pkg::LOAD}) &&
                     (ins.r.rd != '0);
  assign op_b      = (opc == rv_pkg::OP || opc == rv_pkg::BRANCH) ? rs2_data_i :
                     (opc == rv_pkg::STORE) ? imm_s : imm_i;

  always_comb begin
    alu_op = rv_pkg::ALU_ADD;
    if (opc == rv_pkg::OP || opc == rv_pkg::OP_IMM) begin
      case (ins.r.funct3)
        3'b000: begin
          if (opc == rv_pkg::OP && ins.r.funct7[5]) begin
            alu_op = rv_pkg::ALU_SUB;
          end
        end
        3'b010: alu_op = rv_pkg::ALU_SLT;
        3'b100: alu_op = rv_pkg::ALU_XOR;
        3'b110: alu_op = rv_pkg::ALU_OR;
        3'b111: alu_op = rv_pkg::ALU_AND;
        default: alu_op = rv_pkg::ALU_ADD;
      endcase
    end
  end

  // Wait while an older instruction in ALU or memory still owes a source register
  assign hazard = fetch_i.valid && (
      (alu_mon_i.valid && alu_mon_i.wr_en &&
       (alu_mon_i.rd == ins.r.rs1 || (uses_rs2 && alu_mon_i.rd == ins.r.rs2))) ||
      (mem_mon_i.valid && mem_mon_i.wr_en &&
       (mem_mon_i.rd == ins.r.rs1 || (uses_rs2 && mem_mon_i.rd == ins.r.rs2))));

  assign fetch_i.stall = hazard || (fetch_i.valid && alu_o.stall);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      alu_o.valid <= 1'b0;
    end else if (redirect_i) begin
      alu_o.valid <= 1'b0;
    end else if (!alu_o.stall) begin
      alu_o.valid <= fetch_i.valid && !hazard;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!alu_o.stall) begin
      alu_o.pc            <= fetch_i.pc;
      alu_o.alu_op        <= alu_op;
      alu_o.op_a          <= rs1_data_i;
      alu_o.op_b          <= op_b;
      alu_o.store_data    <= rs2_data_i;
      alu_o.rd            <= ins.r.rd;
      alu_o.wr_en         <= wr_en;
      alu_o.is_load       <= opc == rv_pkg::LOAD;
      alu_o.is_store      <= opc == rv_pkg::STORE;
      alu_o.is_branch     <= is_branch;
      alu_o.branch_ne     <= ins.b.funct3 == rv_pkg::F3_BNE;
      alu_o.branch_offset <= imm_b[ADDR_WIDTH-1:0];
    end
  end

  // Held instruction must not change under a stall
  assert property (@(posedge clk_i) disable iff (!rst_i)
    fetch_i.stall && !redirect_i |=>
      fetch_i.valid && $stable(fetch_i.instr) && $stable(fetch_i.pc));

endmodule

`default_nettype wire

// File: decode/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
  input  wire                       clk_i,
  input  wire                       rst_i,
  input  wire                       wb_en_i,
  input  wire  [rv_pkg::REG_AW-1:0] wb_rd_i,
  input  wire  [rv_pkg::XLEN-1:0]   wb_data_i,
  input  wire  [rv_pkg::REG_AW-1:0] rs1_idx_i,
  input  wire  [rv_pkg::REG_AW-1:0] rs2_idx_i,
  output logic [rv_pkg::XLEN-1:0]   rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]   rs2_data_o
);

  // No storage behind x0
  logic [rv_pkg::XLEN-1:0] regs [1:rv_pkg::NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (rst_i && wb_en_i && wb_rd_i != '0) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  // Same-cycle write shows up on the read side
  assign rs1_data_o = (rs1_idx_i == '0) ? '0 :
                      (wb_en_i && wb_rd_i == rs1_idx_i) ? wb_data_i : regs[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 :
                      (wb_en_i && wb_rd_i == rs2_idx_i) ? wb_data_i : regs[rs2_idx_i];

endmodule

`default_nettype wire

// File: fetch/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter int                    ADDR_WIDTH = 16,
  parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     mem_busy_i,
  input  wire                     redirect_i,
  input  wire  [ADDR_WIDTH-1:0]   target_i,
  input  wire                     resp_valid_i,
  input  wire  [rv_pkg::XLEN-1:0] resp_instr_i,
  output logic                    req_o,
  output logic                    pending_o,
  output logic [ADDR_WIDTH-1:0]   req_addr_o,
  fetch_dec_if.producer           dec_o
);

  logic [ADDR_WIDTH-1:0] pc_q;
  logic [ADDR_WIDTH-1:0] req_addr_q;
  logic                  pending_q;
  logic                  discard_q;
  logic                  start;
  logic                  take;

  // Only start when the output slot is free, so a response always has a place
  assign start = !pending_q && !mem_busy_i && !redirect_i && !(dec_o.valid && dec_o.stall);
  assign take  = resp_valid_i && !discard_q && !redirect_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q        <= RESET_PC;
      pending_q   <= 1'b0;
      discard_q   <= 1'b0;
      dec_o.valid <= 1'b0;
    end else begin
      if (redirect_i) begin
        pc_q <= target_i;
      end else if (start) begin
        pc_q <= pc_q + ADDR_WIDTH'(4);
      end

      if (start) begin
        pending_q <= 1'b1;
      end else if (resp_valid_i) begin
        pending_q <= 1'b0;
      end

      // Read already on the bus when the branch hit, its word is junk
      if (resp_valid_i) begin
        discard_q <= 1'b0;
      end else if (redirect_i && pending_q) begin
        discard_q <= 1'b1;
      end

      if (redirect_i) begin
        dec_o.valid <= 1'b0;
      end else if (take) begin
        dec_o.valid <= 1'b1;
      end else if (!dec_o.stall) begin
        dec_o.valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      req_addr_q <= pc_q;
    end
    if (take) begin
      dec_o.pc    <= req_addr_q;
      dec_o.instr <= resp_instr_i;
    end
  end

  assign req_o      = pending_q;
  assign pending_o  = pending_q;
  assign req_addr_o = req_addr_q;

  assert property (@(posedge clk_i) disable iff (!rst_i)
    pending_q && !resp_valid_i |=> pending_q && $stable(req_addr_o));

endmodule

`default_nettype wire

// File: rv_pipe.f
common/rv_pkg.sv
common/rv_stage_if.sv
fetch/fetch_stage.sv
decode/reg_bank.sv
decode/decode_stage.sv
verilog/alu_stage.sv
verilog/mem_stage.sv
verilog/rv_pipe_top.sv
tests/rv_pipe_checker.sv
tests/rv_pipe_tb.sv

// File: tests/program_input.hex
// Word count N, then N instruction words from RESET_PC
// Store count M, then M lines of expected store address and data
0000001b
00500093 // 00 addi x1, x0, 5
ffd00113 // 04 addi x2, x0, -3
002081b3 // 08 add  x3, x1, x2
10302023 // 0c sw   x3, 0x100(x0)
40208233 // 10 sub  x4, x1, x2
10402223 // 14 sw   x4, 0x104(x0)
001122b3 // 18 slt  x5, x2, x1
10502423 // 1c sw   x5, 0x108(x0)
0f00c313 // 20 xori x6, x1, 0x0f0
03c37393 // 24 andi x7, x6, 0x03c
7003e413 // 28 ori  x8, x7, 0x700
10802623 // 2c sw   x8, 0x10c(x0)
10402503 // 30 lw   x10, 0x104(x0)
006505b3 // 34 add  x11, x10, x6
10b02823 // 38 sw   x11, 0x110(x0)
00700013 // 3c addi x0, x0, 7
10002a23 // 40 sw   x0, 0x114(x0)
00209463 // 44 bne  x1, x2, +8 (taken)
1e102823 // 48 sw   x1, 0x1f0(x0) skipped marker
00208463 // 4c beq  x1, x2, +8 (not taken)
00224633 // 50 xor  x12, x4, x2
10c02c23 // 54 sw   x12, 0x118(x0)
00528463 // 58 beq  x5, x5, +8 (taken)
1e202a23 // 5c sw   x2, 0x1f4(x0) skipped marker
401106b3 // 60 sub  x13, x2, x1
10d02e23 // 64 sw   x13, 0x11c(x0)
00000063 // 68 beq  x0, x0, 0
00000008
00000100 00000002
00000104 00000008
00000108 00000001
0000010c 00000734
00000110 000000fd
00000114 00000000
00000118 fffffff5
0000011c fffffff8

// File: tests/rv_pipe_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_checker #(
  parameter int                    ADDR_WIDTH = 16,
  parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wire                  rd_req_valid_i,
  input  wire                  wr_req_valid_i,
  input  wire                  req_is_instr_i,
  input  wire [ADDR_WIDTH-1:0] req_address_i,
  input  wire [31:0]           wr_data_i,
  input  wire                  mem_data_valid_i,
  output int                   error_count_o = 0,
  output int                   stores_seen_o = 0
);

  logic [31:0]           exp_addr [0:63];
  logic [31:0]           exp_data [0:63];
  int                    exp_count     = 0;
  logic                  reset_seen    = 1'b0;
  logic                  first_pending = 1'b1;
  logic                  last_open     = 1'b0;
  logic                  last_rd;
  logic                  last_wr;
  logic                  last_instr;
  logic [ADDR_WIDTH-1:0] last_addr;
  logic [31:0]           last_data;

  task automatic add_expected_store(input logic [31:0] addr, input logic [31:0] data);
    if (exp_count < 64) begin
      exp_addr[exp_count] = addr;
      exp_data[exp_count] = data;
      exp_count = exp_count + 1;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    error_count_o = error_count_o + 1;
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL time %0t: %s expected %h actual %h", $time, name, expected, actual);
      error_count_o = error_count_o + 1;
    end
  endtask

  // Stores are acknowledged in program order
  task automatic check_store;
    if (stores_seen_o >= exp_count) begin
      report_error($sformatf("unexpected store of %h to address %h", wr_data_i, req_address_i));
    end else begin
      compare_value("req_address_o", exp_addr[stores_seen_o], 32'(req_address_i));
      compare_value("wr_data_o", exp_data[stores_seen_o], wr_data_i);
    end
    stores_seen_o = stores_seen_o + 1;
  endtask

  always @(posedge clk_i) begin
    if (!rst_i) begin
      // Outputs are unknown until the first reset edge
      if (reset_seen && (rd_req_valid_i !== 1'b0 || wr_req_valid_i !== 1'b0)) begin
        report_error("memory request active while reset is asserted");
      end
      reset_seen    <= 1'b1;
      first_pending <= 1'b1;
      last_open     <= 1'b0;
    end else begin
      if (rd_req_valid_i && wr_req_valid_i) begin
        report_error("read and write requests asserted together");
      end
      if (first_pending && (rd_req_valid_i || wr_req_valid_i)) begin
        compare_value("rd_req_valid_o", 32'd1, 32'(rd_req_valid_i));
        compare_value("req_is_instr_o", 32'd1, 32'(req_is_instr_i));
        compare_value("req_address_o", 32'(RESET_PC), 32'(req_address_i));
        first_pending <= 1'b0;
      end
      // Open request must hold until its response
      if (last_open) begin
        compare_value("rd_req_valid_o", 32'(last_rd), 32'(rd_req_valid_i));
        compare_value("wr_req_valid_o", 32'(last_wr), 32'(wr_req_valid_i));
        compare_value("req_is_instr_o", 32'(last_instr), 32'(req_is_instr_i));
        compare_value("req_address_o", 32'(last_addr), 32'(req_address_i));
        if (last_wr) begin
          compare_value("wr_data_o", last_data, wr_data_i);
        end
      end
      if (wr_req_valid_i && mem_data_valid_i) begin
        check_store();
      end
      last_open  <= (rd_req_valid_i || wr_req_valid_i) && !mem_data_valid_i;
      last_rd    <= rd_req_valid_i;
      last_wr    <= wr_req_valid_i;
      last_instr <= req_is_instr_i;
      last_addr  <= req_address_i;
      last_data  <= wr_data_i;
    end
  end

endmodule

`default_nettype wire

// File: tests/rv_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_tb;

  localparam int                    ADDR_WIDTH = 16;
  localparam logic [ADDR_WIDTH-1:0] RESET_PC   = '0;
  localparam int                    MEM_WORDS  = 1 << (ADDR_WIDTH - 2);

  logic                  clk_i;
  logic                  rst_i;
  logic                  mem_data_valid_i;
  logic                  mem_data_is_instr_i;
  logic [31:0]           mem_data_i;
  logic                  rd_req_valid_o;
  logic                  wr_req_valid_o;
  logic                  req_is_instr_o;
  logic [ADDR_WIDTH-1:0] req_address_o;
  logic [31:0]           wr_data_o;
  int                    error_count;
  int                    stores_seen;

  logic [31:0]           input_words [0:127];
  logic [31:0]           mem [0:MEM_WORDS-1];
  int                    n_words;
  int                    m_stores;
  int                    cycle_limit = 0;
  int                    seed = 32'h26ce4605;
  logic                  busy;
  int                    wait_cnt;
  logic [ADDR_WIDTH-1:0] req_addr_q;
  logic                  req_wr_q;
  logic                  req_instr_q;
  logic [31:0]           req_data_q;

  rv_pipe_top #(
    .ADDR_WIDTH          (ADDR_WIDTH),
    .RESET_PC            (RESET_PC)
  ) uut (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .mem_data_valid_i    (mem_data_valid_i),
    .mem_data_is_instr_i (mem_data_is_instr_i),
    .mem_data_i          (mem_data_i),
    .rd_req_valid_o      (rd_req_valid_o),
    .wr_req_valid_o      (wr_req_valid_o),
    .req_is_instr_o      (req_is_instr_o),
    .req_address_o       (req_address_o),
    .wr_data_o           (wr_data_o)
  );

  rv_pipe_checker #(
    .ADDR_WIDTH       (ADDR_WIDTH),
    .RESET_PC         (RESET_PC)
  ) chk (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .rd_req_valid_i   (rd_req_valid_o),
    .wr_req_valid_i   (wr_req_valid_o),
    .req_is_instr_i   (req_is_instr_o),
    .req_address_i    (req_address_o),
    .wr_data_i        (wr_data_o),
    .mem_data_valid_i (mem_data_valid_i),
    .error_count_o    (error_count),
    .stores_seen_o    (stores_seen)
  );

  always #50 clk_i = ~clk_i;

  // Memory model, one request at a time, 1 to 4 cycles per answer
  always @(posedge clk_i) begin
    if (!rst_i) begin
      mem_data_valid_i <= 1'b0;
      busy = 1'b0;
    end else begin
      mem_data_valid_i <= 1'b0;
      if (mem_data_valid_i) begin
        busy = 1'b0;
      end else if (!busy && (rd_req_valid_o || wr_req_valid_o)) begin
        busy        = 1'b1;
        wait_cnt    = $random(seed) & 3;
        req_addr_q  = req_address_o;
        req_wr_q    = wr_req_valid_o;
        req_instr_q = req_is_instr_o;
        req_data_q  = wr_data_o;
      end
      if (busy && !mem_data_valid_i) begin
        if (wait_cnt == 0) begin
          mem_data_valid_i    <= 1'b1;
          mem_data_is_instr_i <= req_instr_q;
          if (req_wr_q) begin
            mem[req_addr_q[ADDR_WIDTH-1:2]] <= req_data_q;
          end else begin
            mem_data_i <= mem[req_addr_q[ADDR_WIDTH-1:2]];
          end
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end
    end
  end

  initial begin : main_seq
    int idx;
    clk_i               = 1'b0;
    rst_i               = 1'b0;
    mem_data_valid_i    = 1'b0;
    mem_data_is_instr_i = 1'b0;
    mem_data_i          = '0;
    for (idx = 0; idx < MEM_WORDS; idx++) begin
      mem[idx] = 32'hdead0000 ^ idx;
    end
    $readmemh("tests/program_input.hex", input_words);
    n_words  = input_words[0];
    m_stores = input_words[n_words + 1];
    if (n_words == 0 || m_stores == 0) begin
      chk.report_error("program file tests/program_input.hex is missing or empty");
    end
    for (idx = 0; idx < n_words; idx++) begin
      mem[RESET_PC[ADDR_WIDTH-1:2] + idx] = input_words[idx + 1];
    end
    for (idx = 0; idx < m_stores; idx++) begin
      chk.add_expected_store(input_words[n_words + 2 + 2 * idx],
                             input_words[n_words + 3 + 2 * idx]);
    end
    cycle_limit = (n_words + m_stores) * 40;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b1;
    wait (stores_seen >= m_stores);
    // Give a stray store past the last expected one time to show up
    repeat (20) @(posedge clk_i);
    $display("errors: %0d, stores seen: %0d of %0d", error_count, stores_seen, m_stores);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (cycle_limit > 0);
    repeat (cycle_limit) @(posedge clk_i);
    $display("ERROR: timeout after %0d cycles, errors: %0d, stores seen: %0d of %0d",
             cycle_limit, error_count, stores_seen, m_stores);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/alu_stage.sv
`timescale 1ns/1ps
`default_nettype none

module alu_stage #(
  parameter int ADDR_WIDTH = 16
) (
  input  wire                   clk_i,
  input  wire                   rst_i,
  output logic                  redirect_o,
  output logic [ADDR_WIDTH-1:0] target_o,
  dec_alu_if.consumer           dec_i,
  alu_mem_if.producer           mem_o
);

  logic [rv_pkg::XLEN-1:0] result;
  logic                    taken;

  always_comb begin
    case (dec_i.alu_op)
      rv_pkg::ALU_SUB: result = dec_i.op_a - dec_i.op_b;
      rv_pkg::ALU_AND: result = dec_i.op_a & dec_i.op_b;
      rv_pkg::ALU_OR:  result = dec_i.op_a | dec_i.op_b;
      rv_pkg::ALU_XOR: result = dec_i.op_a ^ dec_i.op_b;
      rv_pkg::ALU_SLT: begin
        result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(dec_i.op_a) < $signed(dec_i.op_b)};
      end
      default:         result = dec_i.op_a + dec_i.op_b;
    endcase
  end

  assign taken = dec_i.is_branch && ((dec_i.op_a == dec_i.op_b) != dec_i.branch_ne);

  // Fires once, on the edge the branch leaves this stage
  assign redirect_o = dec_i.valid && taken && !mem_o.stall;
  assign target_o   = dec_i.pc + dec_i.branch_offset;

  // A bubble in front of a blocked memory stage can still be overwritten
  assign dec_i.stall = dec_i.valid && mem_o.stall;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      mem_o.valid <= 1'b0;
    end else if (!mem_o.stall) begin
      mem_o.valid <= dec_i.valid && !dec_i.is_branch;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!mem_o.stall) begin
      mem_o.result     <= result;
      mem_o.store_data <= dec_i.store_data;
      mem_o.rd         <= dec_i.rd;
      mem_o.wr_en      <= dec_i.wr_en;
      mem_o.is_load    <= dec_i.is_load;
      mem_o.is_store   <= dec_i.is_store;
    end
  end

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
  parameter int ADDR_WIDTH = 16
) (
  input  wire                       clk_i,
  input  wire                       rst_i,
  input  wire                       fetch_pending_i,
  input  wire                       resp_valid_i,
  input  wire                       resp_is_instr_i,
  input  wire  [rv_pkg::XLEN-1:0]   resp_data_i,
  output logic                      rd_req_o,
  output logic                      wr_req_o,
  output logic                      busy_o,
  output logic [ADDR_WIDTH-1:0]     req_addr_o,
  output logic [rv_pkg::XLEN-1:0]   wr_data_o,
  output logic                      wb_en_o,
  output logic [rv_pkg::REG_AW-1:0] wb_rd_o,
  output logic [rv_pkg::XLEN-1:0]   wb_data_o,
  alu_mem_if.consumer               alu_i
);

  logic done;

  assign busy_o = alu_i.valid && (alu_i.is_load || alu_i.is_store);

  // Wait for the port while fetch has a read in flight
  assign rd_req_o   = busy_o && alu_i.is_load && !fetch_pending_i;
  assign wr_req_o   = busy_o && alu_i.is_store && !fetch_pending_i;
  assign req_addr_o = alu_i.result[ADDR_WIDTH-1:0];
  assign wr_data_o  = alu_i.store_data;

  assign done        = resp_valid_i && !resp_is_instr_i;
  assign alu_i.stall = busy_o && !done;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_en_o <= 1'b0;
    end else begin
      wb_en_o <= alu_i.valid && alu_i.wr_en && !alu_i.stall;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_o   <= alu_i.rd;
    wb_data_o <= alu_i.is_load ? resp_data_i : alu_i.result;
  end

  assert property (@(posedge clk_i) disable iff (!rst_i) !(rd_req_o && wr_req_o));

endmodule

`default_nettype wire

// File: verilog/rv_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_top #(
  parameter int                    ADDR_WIDTH = 16,
  parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     mem_data_valid_i,
  input  wire                     mem_data_is_instr_i,
  input  wire  [rv_pkg::XLEN-1:0] mem_data_i,
  output logic                    rd_req_valid_o,
  output logic                    wr_req_valid_o,
  output logic                    req_is_instr_o,
  output logic [ADDR_WIDTH-1:0]   req_address_o,
  output logic [rv_pkg::XLEN-1:0] wr_data_o
);

  logic                      fetch_req;
  logic                      fetch_pending;
  logic [ADDR_WIDTH-1:0]     fetch_addr;
  logic                      mem_busy;
  logic                      mem_rd_req;
  logic                      mem_wr_req;
  logic [ADDR_WIDTH-1:0]     mem_addr;
  logic                      redirect;
  logic [ADDR_WIDTH-1:0]     target;
  logic [rv_pkg::REG_AW-1:0] rs1_idx;
  logic [rv_pkg::REG_AW-1:0] rs2_idx;
  logic [rv_pkg::XLEN-1:0]   rs1_data;
  logic [rv_pkg::XLEN-1:0]   rs2_data;
  logic                      wb_en;
  logic [rv_pkg::REG_AW-1:0] wb_rd;
  logic [rv_pkg::XLEN-1:0]   wb_data;

  fetch_dec_if #(.ADDR_WIDTH(ADDR_WIDTH)) fetch_dec ();
  dec_alu_if #(.ADDR_WIDTH(ADDR_WIDTH)) dec_alu ();
  alu_mem_if alu_mem ();

  fetch_stage #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .RESET_PC     (RESET_PC)
  ) fetch_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .mem_busy_i   (mem_busy),
    .redirect_i   (redirect),
    .target_i     (target),
    .resp_valid_i (mem_data_valid_i & mem_data_is_instr_i),
    .resp_instr_i (mem_data_i),
    .req_o        (fetch_req),
    .pending_o    (fetch_pending),
    .req_addr_o   (fetch_addr),
    .dec_o        (fetch_dec)
  );

  decode_stage #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) decode_stage (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .redirect_i (redirect),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_idx_o  (rs1_idx),
    .rs2_idx_o  (rs2_idx),
    .fetch_i    (fetch_dec),
    .alu_o      (dec_alu),
    .alu_mon_i  (dec_alu),
    .mem_mon_i  (alu_mem)
  );

  reg_bank reg_bank (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_en_i    (wb_en),
    .wb_rd_i    (wb_rd),
    .wb_data_i  (wb_data),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  alu_stage #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) alu_stage (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .redirect_o (redirect),
    .target_o   (target),
    .dec_i      (dec_alu),
    .mem_o      (alu_mem)
  );

  mem_stage #(
    .ADDR_WIDTH      (ADDR_WIDTH)
  ) mem_stage (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fetch_pending_i (fetch_pending),
    .resp_valid_i    (mem_data_valid_i),
    .resp_is_instr_i (mem_data_is_instr_i),
    .resp_data_i     (mem_data_i),
    .rd_req_o        (mem_rd_req),
    .wr_req_o        (mem_wr_req),
    .busy_o          (mem_busy),
    .req_addr_o      (mem_addr),
    .wr_data_o       (wr_data_o),
    .wb_en_o         (wb_en),
    .wb_rd_o         (wb_rd),
    .wb_data_o       (wb_data),
    .alu_i           (alu_mem)
  );

  // Shared port goes to fetch for as long as its read is outstanding
  assign rd_req_valid_o = fetch_pending ? fetch_req : mem_rd_req;
  assign wr_req_valid_o = fetch_pending ? 1'b0 : mem_wr_req;
  assign req_is_instr_o = fetch_pending;
  assign req_address_o  = fetch_pending ? fetch_addr : mem_addr;

endmodule

`default_nettype wire
